/* Makefile */
# Verilator build of the scope stream testbench
TOP = scope_stream_tb

.PHONY: all compile run clean

all: run

# Builds obj_dir/V$(TOP) with timing and assertions enabled
compile:
	verilator --binary --timing --assert --top-module $(TOP) -f scope_stream.f

# The executable exits with a nonzero status on $fatal or a failed assertion
run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* scope_stream.f */
source/scope_types_pkg.sv
source/scope_bus_pkg.sv
source/scope_regs.sv
source/channel_select.sv
source/timebase.sv
source/capture_engine.sv
source/scope_stream.sv
testbench/scope_stream_assert.sv
testbench/scope_stream_tb.sv

/* source/capture_engine.sv */
/*
 * Snapshots all channels on a tick and sends them as one frame.
 * Ticks during a frame are dropped and reported as overrun, except on the
 * cycle that transfers the last beat, where the next frame starts at once.
 */
`default_nettype none

module capture_engine
    import scope_types_pkg::*;
#(
    parameter int N_CHANNELS = 6
) (
    input  wire logic                     clock,
    input  wire logic                     arst_n,
    input  wire logic                     tick,
    input  wire sample_t [N_CHANNELS-1:0] channels,
    input  wire sample_t                  trig_level,
    output frame_beat_t                   out_beat,
    output logic                          out_valid,
    input  wire logic                     out_ready,
    output logic                          overrun_set,
    output logic                          trigger
);

    typedef enum logic {
        ST_IDLE,
        ST_SEND
    } state_t;

    state_t                   state_q;
    sample_t [N_CHANNELS-1:0] snap_q;
    chan_idx_t                idx_q;
    sample_t                  prev0_q;
    sample_t                  beat_data;
    logic                     last_beat;
    logic                     beat_done;
    logic                     start;

    assign last_beat = (idx_q == chan_idx_t'(N_CHANNELS - 1));
    assign out_valid = (state_q == ST_SEND);
    // The final beat of the frame is leaving in this cycle
    assign beat_done = out_valid & out_ready & last_beat;
    assign start     = tick & ((state_q == ST_IDLE) | beat_done);

    // Pick the snapshot entry for the current beat
    always_comb begin
        beat_data = '0;
        for (int k = 0; k < N_CHANNELS; k++) begin
            if (idx_q == chan_idx_t'(k)) begin
                beat_data = snap_q[k];
            end
        end
    end

    // The beat only depends on the snapshot and the index, both frozen while stalled
    assign out_beat = '{dest: idx_q, data: beat_data, last: last_beat};

    // Snapshot payload, loaded only when a frame starts
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            snap_q <= '0;
        end else if (start) begin
            snap_q <= channels;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state_q     <= ST_IDLE;
            idx_q       <= '0;
            prev0_q     <= '0;
            trigger     <= 1'b0;
            overrun_set <= 1'b0;
        end else begin
            // Both outputs are single-cycle pulses
            trigger     <= 1'b0;
            overrun_set <= tick & ~start;
            if (start) begin
                state_q <= ST_SEND;
                idx_q   <= '0;
                prev0_q <= channels[0];
                // Upward crossing of channel 0 between consecutive snapshots
                trigger <= (prev0_q < trig_level) && (channels[0] >= trig_level);
            end else if (beat_done) begin
                state_q <= ST_IDLE;
                idx_q   <= '0;
            end else if (out_valid && out_ready) begin
                idx_q <= idx_q + chan_idx_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

/* source/channel_select.sv */
/*
 * Per-channel sample store fed by tag matching.
 * The input stream has no back-pressure and every sample is accepted.
 * A sample whose tag matches several selectors updates all of those channels.
 */
`default_nettype none

module channel_select
    import scope_types_pkg::*;
#(
    parameter int N_CHANNELS = 6
) (
    input  wire logic                       clock,
    input  wire logic                       arst_n,
    input  wire sample_beat_t               in_beat,
    input  wire logic                       in_valid,
    input  wire tag_t [N_CHANNELS-1:0]      selectors,
    output wire sample_t [N_CHANNELS-1:0]   channels
);

    // One slot per channel, all looking at the same input beat
    for (genvar k = 0; k < N_CHANNELS; k++) begin : g_slot
        sample_t slot_q;
        logic    hit;

        // Samples with a tag that no selector holds are simply not loaded
        assign hit = in_valid & (in_beat.tag == selectors[k]);

        // Channels start at zero so a frame before any sample is defined
        always_ff @(posedge clock or negedge arst_n) begin
            if (!arst_n) begin
                slot_q <= '0;
            end else if (hit) begin
                slot_q <= in_beat.data;
            end
        end

        // The latest matching value is visible one cycle after the input beat
        assign channels[k] = slot_q;
    end

endmodule

`default_nettype wire

/* source/scope_bus_pkg.sv */
/*
 * Wishbone classic control bus types and the register map.
 * Addresses are word addresses and every access is a full 32-bit word.
 */
`default_nettype none

package scope_bus_pkg;

    typedef logic [31:0] reg_word_t;
    typedef logic [7:0]  reg_addr_t;

    // Request side, driven by the bus master
    typedef struct packed {
        logic      cyc;
        logic      stb;
        logic      we;
        reg_addr_t adr;
        reg_word_t dat;
    } wb_req_t;

    // Response side, driven by the register block
    typedef struct packed {
        logic      ack;
        reg_word_t dat;
    } wb_rsp_t;

    // Register map in word addresses
    localparam reg_addr_t REG_CONTROL    = 8'd0;
    localparam reg_addr_t REG_PERIOD     = 8'd1;
    localparam reg_addr_t REG_TRIG_LEVEL = 8'd2;
    // Selector k lives at REG_SEL_BASE + k
    localparam reg_addr_t REG_SEL_BASE   = 8'd3;

    // Bit positions inside the control register
    localparam int CTRL_ENABLE_BIT  = 0;
    localparam int CTRL_EXT_BIT     = 1;
    localparam int CTRL_OVERRUN_BIT = 8;

endpackage

`default_nettype wire

/* source/scope_regs.sv */
/*
 * Wishbone classic slave with a fixed one-cycle ack.
 * Unmapped addresses read as zero and ignore writes.
 * The overrun bit is sticky and cleared by writing 1 to it.
 */
`default_nettype none

module scope_regs
    import scope_types_pkg::*;
    import scope_bus_pkg::*;
#(
    parameter int N_CHANNELS = 6
) (
    input  wire logic             clock,
    input  wire logic             arst_n,
    input  wire wb_req_t          wb_req,
    output wb_rsp_t               wb_rsp,
    input  wire logic             overrun_set,
    output logic                  enable,
    output logic                  external_capture,
    output reg_word_t             period,
    output sample_t               trig_level,
    output tag_t [N_CHANNELS-1:0] selectors
);

    logic      access;
    logic      write;
    logic      ack_q;
    logic      overrun_q;
    reg_word_t rd_data;
    reg_word_t rd_data_q;

    // A new access starts only while ack is low, so every request gets one ack
    assign access = wb_req.cyc & wb_req.stb & ~ack_q;
    assign write  = access & wb_req.we;

    // Read-back multiplexer, decoded from the address held by the master
    always_comb begin
        rd_data = '0;
        case (wb_req.adr)
            REG_CONTROL: begin
                rd_data[CTRL_ENABLE_BIT]  = enable;
                rd_data[CTRL_EXT_BIT]     = external_capture;
                rd_data[CTRL_OVERRUN_BIT] = overrun_q;
            end
            REG_PERIOD:     rd_data = period;
            REG_TRIG_LEVEL: rd_data[$bits(sample_t)-1:0] = trig_level;
            default: ;
        endcase
        // Selectors occupy a window sized by the channel count
        for (int k = 0; k < N_CHANNELS; k++) begin
            if (wb_req.adr == reg_addr_t'(REG_SEL_BASE + k)) begin
                rd_data[$bits(tag_t)-1:0] = selectors[k];
            end
        end
    end

    // Ack and read data rise together on the edge after the request
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ack_q     <= 1'b0;
            rd_data_q <= '0;
        end else begin
            ack_q <= access;
            if (access) begin
                rd_data_q <= rd_data;
            end
        end
    end

    // Writable registers, updated on the edge that raises ack
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            enable           <= 1'b0;
            external_capture <= 1'b0;
            period           <= '0;
            trig_level       <= '0;
            selectors        <= '0;
        end else if (write) begin
            case (wb_req.adr)
                REG_CONTROL: begin
                    enable           <= wb_req.dat[CTRL_ENABLE_BIT];
                    external_capture <= wb_req.dat[CTRL_EXT_BIT];
                end
                REG_PERIOD:     period     <= wb_req.dat;
                REG_TRIG_LEVEL: trig_level <= wb_req.dat[$bits(sample_t)-1:0];
                default: ;
            endcase
            // Only the tag width of a selector write is kept
            for (int k = 0; k < N_CHANNELS; k++) begin
                if (wb_req.adr == reg_addr_t'(REG_SEL_BASE + k)) begin
                    selectors[k] <= wb_req.dat[$bits(tag_t)-1:0];
                end
            end
        end
    end

    // A new overrun wins over a clear in the same cycle so no event is lost
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            overrun_q <= 1'b0;
        end else if (overrun_set) begin
            overrun_q <= 1'b1;
        end else if (write && wb_req.adr == REG_CONTROL && wb_req.dat[CTRL_OVERRUN_BIT]) begin
            overrun_q <= 1'b0;
        end
    end

    assign wb_rsp = '{ack: ack_q, dat: rd_data_q};

endmodule

`default_nettype wire

/* source/scope_stream.sv */
/*
 * Streaming oscilloscope front end on a Wishbone classic bus.
 * N_CHANNELS may range from 1 to 8. The input stream has no ready.
 */
`default_nettype none

module scope_stream
    import scope_types_pkg::*;
    import scope_bus_pkg::*;
#(
    parameter int N_CHANNELS = 6
) (
    input  wire logic         clock,
    input  wire logic         arst_n,
    input  wire logic         sampling_clock,
    input  wire wb_req_t      wb_req,
    output wire wb_rsp_t      wb_rsp,
    input  wire sample_beat_t in_beat,
    input  wire logic         in_valid,
    output wire frame_beat_t  out_beat,
    output wire logic         out_valid,
    input  wire logic         out_ready,
    output wire logic         trigger
);

    // Control fields fanned out from the register block
    logic                     enable;
    logic                     external_capture;
    reg_word_t                period;
    sample_t                  trig_level;
    tag_t [N_CHANNELS-1:0]    selectors;
    // Data path between the stages
    sample_t [N_CHANNELS-1:0] channels;
    logic                     tick;
    logic                     overrun_set;

    scope_regs #(
        .N_CHANNELS(N_CHANNELS)
    ) i_regs (
        .clock(clock),
        .arst_n(arst_n),
        .wb_req(wb_req),
        .wb_rsp(wb_rsp),
        .overrun_set(overrun_set),
        .enable(enable),
        .external_capture(external_capture),
        .period(period),
        .trig_level(trig_level),
        .selectors(selectors)
    );

    channel_select #(
        .N_CHANNELS(N_CHANNELS)
    ) i_select (
        .clock(clock),
        .arst_n(arst_n),
        .in_beat(in_beat),
        .in_valid(in_valid),
        .selectors(selectors),
        .channels(channels)
    );

    timebase i_timebase (
        .clock(clock),
        .arst_n(arst_n),
        .sampling_clock(sampling_clock),
        .enable(enable),
        .external_capture(external_capture),
        .period(period),
        .tick(tick)
    );

    capture_engine #(
        .N_CHANNELS(N_CHANNELS)
    ) i_capture (
        .clock(clock),
        .arst_n(arst_n),
        .tick(tick),
        .channels(channels),
        .trig_level(trig_level),
        .out_beat(out_beat),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .overrun_set(overrun_set),
        .trigger(trigger)
    );

endmodule

`default_nettype wire

/* source/scope_types_pkg.sv */
/*
 * Data path types for the scope stream front end.
 * Samples are 24 bits wide and are compared as unsigned values.
 */
`default_nettype none

package scope_types_pkg;

    // One sample value as carried on the input and output streams
    typedef logic [23:0] sample_t;

    // Source address attached to every input sample
    typedef logic [7:0] tag_t;

    // Channel number placed in the dest field of output beats
    typedef logic [7:0] chan_idx_t;

    // Input stream payload, qualified by a separate valid bit
    typedef struct packed {
        tag_t    tag;
        sample_t data;
    } sample_beat_t;

    // Output stream payload, qualified by valid and ready
    typedef struct packed {
        chan_idx_t dest;
        sample_t   data;
        logic      last;
    } frame_beat_t;

endpackage

`default_nettype wire

/* source/timebase.sv */
/*
 * Sample tick generator with an internal divider or an external clock.
 * Internal ticks come every max(period, 2) cycles while enabled.
 * External edges pass a two-flop synchronizer, adding 2 to 3 cycles of latency.
 */
`default_nettype none

module timebase
    import scope_bus_pkg::*;
(
    input  wire logic      clock,
    input  wire logic      arst_n,
    input  wire logic      sampling_clock,
    input  wire logic      enable,
    input  wire logic      external_capture,
    input  wire reg_word_t period,
    output logic           tick
);

    reg_word_t  count_q;
    reg_word_t  last_count;
    logic [1:0] sync_q;
    logic       ext_prev_q;
    logic       int_wrap;
    logic       ext_rise;

    // Periods below 2 are clamped so ticks never come back to back
    assign last_count = (period < reg_word_t'(2)) ? reg_word_t'(1) : period - reg_word_t'(1);

    // Greater-or-equal also catches a period shortened while counting
    assign int_wrap = enable & ~external_capture & (count_q >= last_count);

    // The counter sits at zero while disabled, so it restarts when enable rises
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            count_q <= '0;
        end else if (!enable || external_capture || int_wrap) begin
            count_q <= '0;
        end else begin
            count_q <= count_q + reg_word_t'(1);
        end
    end

    // sampling_clock is asynchronous to clock
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            sync_q     <= '0;
            ext_prev_q <= 1'b0;
        end else begin
            sync_q     <= {sync_q[0], sampling_clock};
            ext_prev_q <= sync_q[1];
        end
    end

    // Rising edge of the synchronized external clock
    assign ext_rise = enable & external_capture & sync_q[1] & ~ext_prev_q;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            tick <= 1'b0;
        end else begin
            tick <= int_wrap | ext_rise;
        end
    end

endmodule

`default_nettype wire

/* testbench/scope_stream_assert.sv */
/*
 * Protocol assertions bound into scope_stream.
 * Bus rules are sampled on the falling edge, where the master updates its request.
 */
`default_nettype none

module scope_stream_assert
    import scope_types_pkg::*;
    import scope_bus_pkg::*;
(
    input wire logic        clock,
    input wire logic        arst_n,
    input wire wb_req_t     wb_req,
    input wire wb_rsp_t     wb_rsp,
    input wire frame_beat_t out_beat,
    input wire logic        out_valid,
    input wire logic        out_ready,
    input wire logic        trigger
);

    // An ack always answers a request that is still held by the master
    ack_needs_request: assert property (
        @(negedge clock) disable iff (!arst_n)
        wb_rsp.ack |-> (wb_req.cyc && wb_req.stb)
    ) else $error("Wishbone ack seen without cyc and stb");

    // The slave acks for exactly one cycle
    ack_single_cycle: assert property (
        @(negedge clock) disable iff (!arst_n)
        wb_rsp.ack |=> !wb_rsp.ack
    ) else $error("Wishbone ack held for more than one cycle");

    // A stalled beat keeps its valid and its payload
    beat_stable_on_stall: assert property (
        @(posedge clock) disable iff (!arst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_beat))
    ) else $error("Output beat changed while stalled");

    // Trigger is a single-cycle pulse
    trigger_single_cycle: assert property (
        @(posedge clock) disable iff (!arst_n)
        trigger |=> !trigger
    ) else $error("Trigger held for more than one cycle");

endmodule

bind scope_stream scope_stream_assert i_assert (
    .clock(clock),
    .arst_n(arst_n),
    .wb_req(wb_req),
    .wb_rsp(wb_rsp),
    .out_beat(out_beat),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .trigger(trigger)
);

`default_nettype wire

/* testbench/scope_stream_tb.sv */
/*
 * Directed testbench for scope_stream with six channels.
 * Inputs change and outputs are sampled on the falling clock edge.
 * The first failed check stops the run with $fatal.
 */
`default_nettype none

module scope_stream_tb
    import scope_types_pkg::*;
    import scope_bus_pkg::*;
();

    localparam int      N_CHANNELS     = 6;
    localparam int      TIMEOUT        = 400;
    localparam int      EXT_EDGES      = 5;
    localparam sample_t TRIG_THRESHOLD = 24'h40_0000;

    logic         clock = 1'b0;
    logic         arst_n;
    logic         sampling_clock;
    wb_req_t      wb_req;
    wb_rsp_t      wb_rsp;
    sample_beat_t in_beat;
    logic         in_valid;
    frame_beat_t  out_beat;
    logic         out_valid;
    logic         out_ready;
    logic         trigger;

    // Expected selectors and channel values, kept from the register and routing rules
    tag_t        sel_model [N_CHANNELS];
    sample_t     chan_model [N_CHANNELS];
    logic [31:0] rng_state;
    int unsigned cycle_count = 0;
    int unsigned frame_start;
    int unsigned frames_seen = 0;
    int unsigned trigger_count = 0;
    int unsigned trigger_cycle = 0;

    scope_stream #(
        .N_CHANNELS(N_CHANNELS)
    ) i_dut (
        .clock(clock),
        .arst_n(arst_n),
        .sampling_clock(sampling_clock),
        .wb_req(wb_req),
        .wb_rsp(wb_rsp),
        .in_beat(in_beat),
        .in_valid(in_valid),
        .out_beat(out_beat),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .trigger(trigger)
    );

    initial begin
        forever #10 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
    end

    // Completed frames and trigger pulses, counted where outputs are stable
    always @(negedge clock) begin
        if (out_valid && out_ready && out_beat.last) begin
            frames_seen++;
        end
        if (trigger) begin
            trigger_count++;
            trigger_cycle = cycle_count;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Ticks come every max(period, 2) cycles, and a frame of N beats drops the ticks
    // that land before its last beat, so frames start on the first tick at or past N
    function automatic int unsigned frame_interval(input int unsigned period);
        int unsigned tick_gap;
        tick_gap = (period < 2) ? 2 : period;
        return ((N_CHANNELS + tick_gap - 1) / tick_gap) * tick_gap;
    endfunction

    task automatic stop_with_error(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check(input string test_name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (actual !== expected) begin
            stop_with_error($sformatf("Mismatch in %s: expected 0x%0h, actual 0x%0h",
                                      test_name, expected, actual));
        end
    endtask

    task automatic wb_access(input string test_name, input logic we, input reg_addr_t adr,
                             input reg_word_t wdat, output reg_word_t rdat);
        int waited;
        int sel_idx;
        waited = 0;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        do begin
            @(negedge clock);
            waited++;
        end while (!wb_rsp.ack && waited < TIMEOUT);
        if (!wb_rsp.ack) begin
            stop_with_error($sformatf("No Wishbone ack for address %0d in %s", adr, test_name));
        end
        check({test_name, " ack latency"}, 64'd1, 64'(waited));
        rdat   = wb_rsp.dat;
        wb_req = '0;
        // Selector writes keep only the tag width
        sel_idx = int'(adr) - int'(REG_SEL_BASE);
        if (we && sel_idx >= 0 && sel_idx < N_CHANNELS) begin
            sel_model[sel_idx] = tag_t'(wdat);
        end
        // Ack falls on the next edge, so the bus is free after one more cycle
        @(negedge clock);
    endtask

    task automatic wb_write(input string test_name, input reg_addr_t adr, input reg_word_t data);
        reg_word_t unused;
        wb_access(test_name, 1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input string test_name, input reg_addr_t adr, output reg_word_t data);
        wb_access(test_name, 1'b0, adr, '0, data);
    endtask

    task automatic check_reg(input string test_name, input reg_addr_t adr,
                             input reg_word_t expected);
        reg_word_t data;
        wb_read(test_name, adr, data);
        check(test_name, 64'(expected), 64'(data));
    endtask

    task automatic send_sample(input tag_t tag, input sample_t data);
        in_beat  = '{tag: tag, data: data};
        in_valid = 1'b1;
        // Every channel whose selector holds this tag takes the sample
        for (int k = 0; k < N_CHANNELS; k++) begin
            if (tag == sel_model[k]) begin
                chan_model[k] = data;
            end
        end
        @(negedge clock);
        in_valid = 1'b0;
    endtask

    task automatic wait_for_valid(input string test_name);
        int waited;
        waited = 0;
        while (!out_valid && waited < TIMEOUT) begin
            @(negedge clock);
            waited++;
        end
        if (!out_valid) begin
            stop_with_error($sformatf("Timeout waiting for an output beat in %s", test_name));
        end
    endtask

    task automatic wait_until_idle(input string test_name);
        int waited;
        waited = 0;
        while (out_valid && waited < TIMEOUT) begin
            @(negedge clock);
            waited++;
        end
        if (out_valid) begin
            stop_with_error($sformatf("Output stream never went idle in %s", test_name));
        end
    endtask

    // Takes one whole frame with out_ready held high by the caller
    task automatic collect_frame(input string test_name);
        for (int k = 0; k < N_CHANNELS; k++) begin
            wait_for_valid(test_name);
            if (k == 0) begin
                frame_start = cycle_count;
            end
            check({test_name, " dest"}, 64'(k), 64'(out_beat.dest));
            check({test_name, " last"}, 64'(k == N_CHANNELS - 1), 64'(out_beat.last));
            check({test_name, " data"}, 64'(chan_model[k]), 64'(out_beat.data));
            @(negedge clock);
        end
    endtask

    task automatic register_access();
        check("reset ack", 64'd0, 64'(wb_rsp.ack));
        check("reset out_valid", 64'd0, 64'(out_valid));
        check("reset trigger", 64'd0, 64'(trigger));
        check_reg("reset control", REG_CONTROL, 32'h0);
        wb_write("period", REG_PERIOD, 32'hc0de_1234);
        check_reg("period", REG_PERIOD, 32'hc0de_1234);
        wb_write("trig level", REG_TRIG_LEVEL, 32'hab12_3456);
        check_reg("trig level", REG_TRIG_LEVEL, 32'h0012_3456);
        for (int k = 0; k < N_CHANNELS; k++) begin
            wb_write("selector", reg_addr_t'(REG_SEL_BASE + k), {24'h5a5a5a, 8'(k * 37 + 1)});
        end
        // Read back only after all writes, so aliasing between selectors shows
        for (int k = 0; k < N_CHANNELS; k++) begin
            check_reg("selector", reg_addr_t'(REG_SEL_BASE + k), {24'h0, 8'(k * 37 + 1)});
        end
        wb_write("unmapped", reg_addr_t'(REG_SEL_BASE + N_CHANNELS), 32'hffff_ffff);
        check_reg("unmapped", reg_addr_t'(REG_SEL_BASE + N_CHANNELS), 32'h0);
        check_reg("unmapped top", 8'hff, 32'h0);
    endtask

    task automatic channel_routing();
        // Tags three apart leave unmatched tags in the random range
        for (int k = 0; k < N_CHANNELS; k++) begin
            wb_write("routing selector", reg_addr_t'(REG_SEL_BASE + k), 32'(8'h10 + 8'(3 * k)));
        end
        wb_write("routing period", REG_PERIOD, 32'd200);
        out_ready = 1'b1;
        wb_write("routing enable", REG_CONTROL, 32'h1);
        for (int n = 0; n < 64; n++) begin
            rng_state = xorshift(rng_state);
            send_sample(8'h10 + tag_t'(rng_state[3:0]), rng_state[31:8]);
        end
        collect_frame("routing frame");
        wb_write("routing disable", REG_CONTROL, 32'h0);
        wait_until_idle("routing");
    endtask

    task automatic internal_timebase();
        int unsigned first;
        wb_write("timebase period", REG_PERIOD, 32'd20);
        wb_write("timebase enable", REG_CONTROL, 32'h1);
        collect_frame("timebase 20");
        first = frame_start;
        collect_frame("timebase 20");
        check("timebase 20 spacing", 64'(frame_interval(20)), 64'(frame_start - first));
        wb_write("timebase period", REG_PERIOD, 32'd1);
        collect_frame("timebase 1");
        first = frame_start;
        collect_frame("timebase 1");
        check("timebase 1 spacing", 64'(frame_interval(1)), 64'(frame_start - first));
        wb_write("timebase disable", REG_CONTROL, 32'h0);
        wait_until_idle("timebase");
        repeat (4) @(negedge clock);
        // Short tick gaps drop ticks inside frames, which sets overrun
        check_reg("timebase overrun", REG_CONTROL, 32'h100);
        wb_write("timebase clear", REG_CONTROL, 32'h100);
        check_reg("timebase cleared", REG_CONTROL, 32'h0);
    endtask

    task automatic backpressure_overrun();
        frame_beat_t held;
        out_ready = 1'b0;
        wb_write("stall period", REG_PERIOD, 32'd20);
        wb_write("stall enable", REG_CONTROL, 32'h1);
        wait_for_valid("stall");
        held = out_beat;
        // Two more ticks arrive while the first beat is blocked
        repeat (50) begin
            @(negedge clock);
            check("stall valid", 64'd1, 64'(out_valid));
            check("stall beat", 64'(held), 64'(out_beat));
        end
        check_reg("stall overrun", REG_CONTROL, 32'h101);
        wb_write("stall disable", REG_CONTROL, 32'h0);
        repeat (4) @(negedge clock);
        check_reg("stall still set", REG_CONTROL, 32'h100);
        wb_write("stall clear", REG_CONTROL, 32'h100);
        check_reg("stall cleared", REG_CONTROL, 32'h0);
        out_ready = 1'b1;
        collect_frame("stall release");
        wait_until_idle("stall");
    endtask

    task automatic trigger_crossing();
        int unsigned base;
        base = trigger_count;
        wb_write("trigger level", REG_TRIG_LEVEL, 32'(TRIG_THRESHOLD));
        wb_write("trigger period", REG_PERIOD, 32'd40);
        send_sample(sel_model[0], TRIG_THRESHOLD - 24'h10);
        wb_write("trigger enable", REG_CONTROL, 32'h1);
        collect_frame("trigger below");
        check("trigger below", 64'd0, 64'(trigger_count - base));
        send_sample(sel_model[0], TRIG_THRESHOLD);
        collect_frame("trigger crossing");
        check("trigger crossing count", 64'd1, 64'(trigger_count - base));
        // The pulse shares the cycle of the first beat, right after the tick
        check("trigger crossing cycle", 64'(frame_start), 64'(trigger_cycle));
        send_sample(sel_model[0], TRIG_THRESHOLD + 24'h1234);
        collect_frame("trigger above");
        check("trigger above", 64'd1, 64'(trigger_count - base));
        wb_write("trigger disable", REG_CONTROL, 32'h0);
        wait_until_idle("trigger");
    endtask

    task automatic external_sampling();
        int unsigned base;
        base = frames_seen;
        wb_write("external enable", REG_CONTROL, 32'h3);
        // Each high and low phase outlasts the synchronizer and a whole frame
        for (int n = 0; n < EXT_EDGES; n++) begin
            sampling_clock = 1'b1;
            collect_frame("external frame");
            repeat (4) @(negedge clock);
            sampling_clock = 1'b0;
            repeat (8) @(negedge clock);
        end
        repeat (40) @(negedge clock);
        check("external frame count", 64'(EXT_EDGES), 64'(frames_seen - base));
        wb_write("external disable", REG_CONTROL, 32'h0);
    endtask

    initial begin
        arst_n         = 1'b0;
        sampling_clock = 1'b0;
        wb_req         = '0;
        in_beat        = '0;
        in_valid       = 1'b0;
        out_ready      = 1'b0;
        rng_state      = 32'hdec;
        for (int k = 0; k < N_CHANNELS; k++) begin
            sel_model[k]  = '0;
            chan_model[k] = '0;
        end
        repeat (3) @(negedge clock);
        arst_n = 1'b1;
        @(negedge clock);
        register_access();
        channel_routing();
        internal_timebase();
        backpressure_overrun();
        trigger_crossing();
        external_sampling();
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire
